// File: include/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// data path and address width
`define XLEN 32

// register index width (x0..x31)
`define REG_BITS 5

// counter table index width, 256 entries by default
`define BHT_BITS 8

// return stack pointer width, 8 entries by default
`define RAS_BITS 3

// trap handler entry point
`define EXCP_ADDR 32'h0000_0100

`endif

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes of interest to the front end
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_IMM    = 7'b0010011; // plain alu op, no control flow

    // conditional branch layout
    typedef struct packed {
        logic       imm12;   // sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;   // sits where rd's lsb would be
        logic [6:0] opcode;
    } b_type_t;

    // jal layout
    typedef struct packed {
        logic       imm20;   // sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12; // covers rs1 and funct3 positions
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one fetched word, read either as a branch or as a jump
    typedef union packed {
        b_type_t b;
        j_type_t j;
    } instr_u;

endpackage

// File: hdl/bp_pkg.sv
package bp_pkg;

    // what the decoder found in the fetched word
    typedef enum logic [1:0] {
        CF_NONE = 2'b00, // falls through to pc+4
        CF_COND = 2'b01, // beq/bne/blt/bge/bltu/bgeu
        CF_JAL  = 2'b10,
        CF_JALR = 2'b11
    } cf_kind_e;

    // 2-bit saturating counter, msb is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    // state of every counter after reset
    localparam ctr_e CTR_INIT = WEAK_NT;

endpackage

// File: hdl/branch_decode.sv
`include "bp_defines.svh"

module branch_decode (
    input  logic [31:0]           instr,
    output bp_pkg::cf_kind_e      kind,
    output logic [`REG_BITS-1:0]  rs1,
    output logic [`REG_BITS-1:0]  rd,
    output logic [`XLEN-1:0]      imm
);

    import rv_isa_pkg::*;
    import bp_pkg::*;

    instr_u           iw;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_i;

    assign iw = instr_u'(instr);

    // B-type: 13-bit offset, lsb always 0
    assign imm_b = {{(`XLEN-13){iw.b.imm12}},
                    iw.b.imm12,
                    iw.b.imm11,
                    iw.b.imm10_5,
                    iw.b.imm4_1,
                    1'b0};

    // J-type: 21-bit offset, lsb always 0
    assign imm_j = {{(`XLEN-21){iw.j.imm20}},
                    iw.j.imm20,
                    iw.j.imm19_12,
                    iw.j.imm11,
                    iw.j.imm10_1,
                    1'b0};

    // I-type for jalr, upper 12 bits of the word
    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};

    always_comb begin
        kind = CF_NONE;
        imm  = '0;
        rs1  = '0;
        rd   = '0;
        case (iw.b.opcode)
            OP_BRANCH: begin
                kind = CF_COND;
                imm  = imm_b;
                rs1  = iw.b.rs1;
            end
            OP_JAL: begin
                kind = CF_JAL;
                imm  = imm_j;
                rd   = iw.j.rd; // rd == x1 marks a call
            end
            OP_JALR: begin
                kind = CF_JALR;
                imm  = imm_i;
                rs1  = iw.b.rs1; // rs1 == x1 marks a return
                rd   = iw.j.rd;
            end
            default: begin
                kind = CF_NONE; // anything else just falls through
            end
        endcase
    end

endmodule

// File: hdl/pattern_table.sv
`include "bp_defines.svh"

module pattern_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic [`XLEN-1:0]  pc,
    output logic              predict_taken,
    input  logic              old_branch,
    input  logic [`XLEN-1:0]  old_branch_pc,
    input  logic              old_actual
);

    import bp_pkg::*;

    localparam int ENTRIES = 1 << `BHT_BITS;

    ctr_e                 counters [ENTRIES];
    logic [`BHT_BITS-1:0] rd_idx;
    logic [`BHT_BITS-1:0] wr_idx;
    ctr_e                 rd_ctr;

    // next counter state, saturating at both ends
    function automatic ctr_e ctr_step(input ctr_e cur, input logic up);
        ctr_e nxt;
        case (cur)
            STRONG_NT: nxt = up ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = up ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = up ? STRONG_T : WEAK_NT;
            default:   nxt = up ? STRONG_T : WEAK_T;
        endcase
        return nxt;
    endfunction

    assign rd_idx = pc[`BHT_BITS+1:2];            // word index, low bits are always 0
    assign wr_idx = old_branch_pc[`BHT_BITS+1:2];

    assign rd_ctr        = counters[rd_idx];
    assign predict_taken = (rd_ctr == WEAK_T) || (rd_ctr == STRONG_T);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= CTR_INIT;
            end
        end else if (old_branch && !stall) begin
            counters[wr_idx] <= ctr_step(counters[wr_idx], old_actual);
        end
    end

    // execute stage must hand back an aligned branch address
    a_update_aligned: assert property (
        @(posedge clk) disable iff (rst)
        old_branch |-> (old_branch_pc[1:0] == 2'b00)
    ) else $error("pattern_table: misaligned old_branch_pc %h", old_branch_pc);

endmodule

// File: hdl/return_stack.sv
`include "bp_defines.svh"

module return_stack (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic              pop,
    input  logic [`XLEN-1:0]  push_addr,
    output logic [`XLEN-1:0]  top_addr
);

    localparam int DEPTH = 1 << `RAS_BITS;

    logic [`XLEN-1:0]     entries [DEPTH];
    logic [`RAS_BITS-1:0] top;
    logic [`RAS_BITS-1:0] top_inc;
    logic [`RAS_BITS-1:0] top_dec;

    // pointer wraps, so overflow overwrites the oldest entry
    assign top_inc = top + `RAS_BITS'(1);
    assign top_dec = top - `RAS_BITS'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else if (push) begin
            top <= top_inc;
        end else if (pop) begin
            top <= top_dec;
        end
    end

    // return address storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[top_inc] <= push_addr;
        end
    end

    assign top_addr = entries[top]; // predicted return target

    // predictor never asks for both in one cycle
    a_push_pop_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(push && pop)
    ) else $error("return_stack: push and pop in the same cycle");

endmodule

// File: hdl/branch_predictor.sv
`include "bp_defines.svh"

module branch_predictor (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1_data,
    input  logic [`XLEN-1:0]     old_pc,
    input  bp_pkg::cf_kind_e     kind,
    input  logic [`REG_BITS-1:0] rs1,
    input  logic [`REG_BITS-1:0] rd,
    input  logic [`XLEN-1:0]     imm,
    input  logic                 predict_taken,
    input  logic                 old_predict,
    input  logic                 old_actual,
    input  logic                 excp,
    input  logic [`XLEN-1:0]     ras_top_addr,
    output logic                 ras_push,
    output logic                 ras_pop,
    output logic [`XLEN-1:0]     ras_push_addr,
    output logic [`XLEN-1:0]     target_pc,
    output logic [`XLEN-1:0]     sepc,
    output logic                 predict_result,
    output logic                 predict_fail
);

    import bp_pkg::*;

    localparam logic [`REG_BITS-1:0] LINK_REG = `REG_BITS'(1); // x1 / ra

    logic             started;     // low for the first cycle out of reset
    logic [`XLEN-1:0] pc_plus_4;
    logic [`XLEN-1:0] pc_plus_imm;
    logic [`XLEN-1:0] kind_pc;
    logic             kind_taken;
    logic             is_call;
    logic             is_ret;
    logic             ras_enable;

    assign pc_plus_4   = pc + `XLEN'(4);
    assign pc_plus_imm = pc + imm;

    // execute stage disagrees with what was predicted
    assign predict_fail = old_predict != old_actual;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // loads on any trap, stall or not
    always_ff @(posedge clk) begin
        if (rst) begin
            sepc <= '0;
        end else if (excp) begin
            sepc <= pc_plus_4;
        end
    end

    always_comb begin
        case (kind)
            CF_COND: begin
                kind_taken = predict_taken;
                kind_pc    = predict_taken ? pc_plus_imm : pc_plus_4;
            end
            CF_JAL: begin
                kind_taken = 1'b1;
                kind_pc    = pc_plus_imm;
            end
            CF_JALR: begin
                kind_taken = 1'b1;
                kind_pc    = (rs1 == LINK_REG) ? ras_top_addr : rs1_data + imm;
            end
            default: begin
                kind_taken = 1'b0;
                kind_pc    = pc_plus_4;
            end
        endcase
    end

    // trap first, then startup, then mispredict repair
    always_comb begin
        if (excp) begin
            target_pc = `EXCP_ADDR;
        end else if (!started) begin
            target_pc = '0;
        end else if (predict_fail) begin
            target_pc = old_pc;
        end else begin
            target_pc = kind_pc;
        end
    end

    always_comb begin
        if (!started) begin
            predict_result = 1'b0;
        end else if (predict_fail) begin
            predict_result = old_actual;
        end else begin
            predict_result = kind_taken;
        end
    end

    assign is_call = ((kind == CF_JAL) || (kind == CF_JALR)) && (rd == LINK_REG);
    assign is_ret  = (kind == CF_JALR) && (rs1 == LINK_REG) && (rd != LINK_REG);

    // a flushed or frozen fetch must not touch the stack
    assign ras_enable    = started && !stall && !predict_fail && !excp;
    assign ras_push      = ras_enable && is_call;
    assign ras_pop       = ras_enable && is_ret;
    assign ras_push_addr = pc_plus_4;

    // execute cannot report a mispredict and a trap together
    a_fail_excp_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(predict_fail && excp)
    ) else $error("branch_predictor: predict_fail and excp both high");

endmodule

// File: hdl/frontend_top.sv
`include "bp_defines.svh"

module frontend_top (
    input  logic              clk,
    input  logic              rst,
    input  logic [`XLEN-1:0]  pc,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic              stall,
    input  logic [`XLEN-1:0]  old_pc,
    input  logic [`XLEN-1:0]  old_branch_pc,
    input  logic              old_branch,
    input  logic              old_predict,
    input  logic              old_actual,
    input  logic              excp,
    output logic [`XLEN-1:0]  target_pc,
    output logic              predict_result,
    output logic              predict_fail,
    output logic [`XLEN-1:0]  sepc
);

    import bp_pkg::*;

    cf_kind_e             kind;
    logic [`REG_BITS-1:0] rs1;
    logic [`REG_BITS-1:0] rd;
    logic [`XLEN-1:0]     imm;
    logic                 predict_taken;
    logic                 ras_push;
    logic                 ras_pop;
    logic [`XLEN-1:0]     ras_push_addr;
    logic [`XLEN-1:0]     ras_top_addr;

    branch_decode u_decode (
        .instr (instr),
        .kind  (kind),
        .rs1   (rs1),
        .rd    (rd),
        .imm   (imm)
    );

    pattern_table u_pht (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .pc            (pc),
        .predict_taken (predict_taken),
        .old_branch    (old_branch),
        .old_branch_pc (old_branch_pc),
        .old_actual    (old_actual)
    );

    return_stack u_ras (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (ras_push_addr),
        .top_addr  (ras_top_addr)
    );

    branch_predictor u_pred (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .pc             (pc),
        .rs1_data       (rs1_data),
        .old_pc         (old_pc),
        .kind           (kind),
        .rs1            (rs1),
        .rd             (rd),
        .imm            (imm),
        .predict_taken  (predict_taken),
        .old_predict    (old_predict),
        .old_actual     (old_actual),
        .excp           (excp),
        .ras_top_addr   (ras_top_addr),
        .ras_push       (ras_push),
        .ras_pop        (ras_pop),
        .ras_push_addr  (ras_push_addr),
        .target_pc      (target_pc),
        .sepc           (sepc),
        .predict_result (predict_result),
        .predict_fail   (predict_fail)
    );

endmodule

// File: bench/tb_frontend.sv
`include "bp_defines.svh"

module tb_frontend;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import bp_pkg::*;

    localparam int EDGE_TIMEOUT  = 200; // ns allowed between rising edges
    localparam int RANDOM_CYCLES = 300;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
    logic [`XLEN-1:0] rs1_data;
    logic             stall;
    logic [`XLEN-1:0] old_pc;
    logic [`XLEN-1:0] old_branch_pc;
    logic             old_branch;
    logic             old_predict;
    logic             old_actual;
    logic             excp;
    logic [`XLEN-1:0] target_pc;
    logic             predict_result;
    logic             predict_fail;
    logic [`XLEN-1:0] sepc;

    // model state as it stands after the coming edge
    ctr_e                 m_ctr [1 << `BHT_BITS];
    logic [`XLEN-1:0]     m_ras [1 << `RAS_BITS];
    logic [`RAS_BITS-1:0] m_top;
    logic [`XLEN-1:0]     m_sepc;
    logic                 m_started = 1'b0;

    logic [15:0] lfsr_state = 16'd95;
    int unsigned edge_cnt   = 0;
    time         edge_time  = 0;
    int          err_cnt    = 0;
    int          test_base  = 0;
    int          pass_cnt   = 0;
    int          fail_cnt   = 0;

    frontend_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt  <= edge_cnt + 1;
        edge_time <= $time;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        instr_u u;
        u = '0;
        u.b.opcode  = OP_BRANCH;
        u.b.imm12   = off[12];
        u.b.imm11   = off[11];
        u.b.imm10_5 = off[10:5];
        u.b.imm4_1  = off[4:1];
        return u;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rdst, input logic [20:0] off);
        instr_u u;
        u = '0;
        u.j.opcode   = OP_JAL;
        u.j.rd       = rdst;
        u.j.imm20    = off[20];
        u.j.imm19_12 = off[19:12];
        u.j.imm11    = off[11];
        u.j.imm10_1  = off[10:1];
        return u;
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rdst, input logic [4:0] src,
                                             input logic [11:0] off);
        instr_u      u;
        logic [31:0] w;
        u = '0;
        u.j.opcode = OP_JALR;
        u.j.rd     = rdst;
        u.b.rs1    = src;
        w = u;
        w[31:20] = off; // I-type immediate has no view of its own
        return w;
    endfunction

    // decode straight from the RV32I field layout
    function automatic void ref_decode(input logic [31:0] w, output cf_kind_e k,
                                       output logic [4:0] r1, output logic [4:0] rdst,
                                       output logic [31:0] im);
        k    = CF_NONE;
        r1   = w[19:15];
        rdst = w[11:7];
        im   = '0;
        case (w[6:0])
            OP_BRANCH: begin
                k  = CF_COND;
                im = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OP_JAL: begin
                k  = CF_JAL;
                im = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OP_JALR: begin
                k  = CF_JALR;
                im = {{20{w[31]}}, w[31:20]};
            end
            default: k = CF_NONE;
        endcase
    endfunction

    function automatic void predict_ref(output logic [31:0] t, output logic res,
                                        output logic fl);
        cf_kind_e    k;
        logic [4:0]  r1;
        logic [4:0]  rdst;
        logic [31:0] im;
        logic [31:0] kpc;
        logic        kres;
        ref_decode(instr, k, r1, rdst, im);
        kres = 1'b1;
        case (k)
            CF_COND: begin
                kres = m_ctr[pc[`BHT_BITS+1:2]] inside {WEAK_T, STRONG_T};
                kpc  = kres ? pc + im : pc + 32'd4;
            end
            CF_JAL:  kpc = pc + im;
            CF_JALR: kpc = (r1 == 5'd1) ? m_ras[m_top] : rs1_data + im;
            default: begin
                kres = 1'b0;
                kpc  = pc + 32'd4;
            end
        endcase
        fl = old_predict != old_actual;
        if (excp) t = `EXCP_ADDR;
        else if (!m_started) t = '0;
        else if (fl) t = old_pc;
        else t = kpc;
        res = !m_started ? 1'b0 : (fl ? old_actual : kres);
    endfunction

    // advance the model by one edge using this cycle's inputs
    function automatic void model_update();
        cf_kind_e             k;
        logic [4:0]           r1;
        logic [4:0]           rdst;
        logic [31:0]          im;
        logic                 en;
        logic [`BHT_BITS-1:0] idx;
        if (rst) begin
            for (int i = 0; i < (1 << `BHT_BITS); i++) m_ctr[i] = WEAK_NT;
            m_top     = '0;
            m_sepc    = '0;
            m_started = 1'b0;
        end else begin
            ref_decode(instr, k, r1, rdst, im);
            en = m_started && !stall && (old_predict == old_actual) && !excp;
            if (en && (k == CF_JAL || k == CF_JALR) && rdst == 5'd1) begin
                m_top        = m_top + `RAS_BITS'(1);
                m_ras[m_top] = pc + 32'd4;
            end else if (en && k == CF_JALR && r1 == 5'd1) begin
                m_top = m_top - `RAS_BITS'(1);
            end
            if (excp) m_sepc = pc + 32'd4;
            if (old_branch && !stall) begin
                idx = old_branch_pc[`BHT_BITS+1:2];
                if (old_actual && m_ctr[idx] != STRONG_T) m_ctr[idx] = ctr_e'(m_ctr[idx] + 2'd1);
                if (!old_actual && m_ctr[idx] != STRONG_NT) m_ctr[idx] = ctr_e'(m_ctr[idx] - 2'd1);
            end
            m_started = 1'b1;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // returns at the next rising edge plus offset ns
    task automatic wait_edge(input int offset);
        int unsigned start_cnt;
        int          waited;
        start_cnt = edge_cnt;
        waited    = 0;
        while (edge_cnt == start_cnt && waited < EDGE_TIMEOUT) begin
            #1;
            waited++;
        end
        if (edge_cnt == start_cnt) begin
            $display("timeout: the clock made no rising edge within %0d ns", EDGE_TIMEOUT);
            $display("Some tests failed");
            $finish;
        end else begin
            #(edge_time + offset - $time);
        end
    endtask

    task automatic next_cycle();
        wait_edge(5); // inputs change 5 ns after the edge
    endtask

    task automatic quiet_execute();
        stall         = 1'b0;
        old_branch    = 1'b0;
        old_predict   = 1'b0;
        old_actual    = 1'b0;
        excp          = 1'b0;
        old_pc        = '0;
        old_branch_pc = '0;
    endtask

    task automatic expect_pred(input logic [31:0] exp_target, input logic exp_result);
        #20;
        check("target_pc", target_pc, exp_target);
        check("predict_result", 32'(predict_result), 32'(exp_result));
    endtask

    task automatic finish_test(input string name);
        #40; // past the compare point of the last cycle
        if (err_cnt == test_base) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - test_base);
        end
        test_base = err_cnt;
    endtask

    // compares every cycle once the outputs have settled
    initial begin
        logic [31:0] exp_target;
        logic        exp_result;
        logic        exp_fail;
        forever begin
            wait_edge(40);
            if (!rst) begin
                predict_ref(exp_target, exp_result, exp_fail);
                check("target_pc", target_pc, exp_target);
                check("predict_result", 32'(predict_result), 32'(exp_result));
                check("predict_fail", 32'(predict_fail), 32'(exp_fail));
                check("sepc", sepc, m_sepc);
            end
            model_update();
        end
    end

    initial begin
        logic [1:0] sel;
        rst      = 1'b1;
        pc       = '0;
        instr    = {25'h0, OP_IMM};
        rs1_data = '0;
        quiet_execute();
        repeat (4) next_cycle();

        rst   = 1'b0;
        pc    = 32'h0000_2000;
        instr = {25'h12345, OP_IMM};
        expect_pred(32'h0, 1'b0); // start-up cycle
        for (int i = 1; i <= 4; i++) begin
            next_cycle();
            pc = 32'h0000_2000 + 32'(4 * i);
            expect_pred(pc + 32'd4, 1'b0);
            check("sepc", sepc, 32'h0);
        end
        finish_test("startup and sequential");

        next_cycle();
        pc    = 32'h0000_3000;
        instr = enc_branch(13'h040);
        expect_pred(32'h3004, 1'b0);
        repeat (2) begin
            next_cycle();
            old_branch    = 1'b1;
            old_branch_pc = 32'h0000_3000;
            old_predict   = 1'b1;
            old_actual    = 1'b1;
        end
        next_cycle();
        old_branch = 1'b0;
        expect_pred(32'h3040, 1'b1);
        repeat (3) begin
            next_cycle();
            old_branch  = 1'b1;
            old_predict = 1'b0;
            old_actual  = 1'b0;
        end
        next_cycle();
        old_branch = 1'b0;
        expect_pred(32'h3004, 1'b0);
        next_cycle();
        old_branch  = 1'b1; // one taken from the bottom stays not taken
        old_predict = 1'b1;
        old_actual  = 1'b1;
        next_cycle();
        old_branch = 1'b0;
        expect_pred(32'h3004, 1'b0);
        repeat (2) begin
            next_cycle();
            stall      = 1'b1;
            old_branch = 1'b1;
            expect_pred(32'h3004, 1'b0);
        end
        next_cycle();
        quiet_execute();
        expect_pred(32'h3004, 1'b0);
        finish_test("conditional branch counters");

        next_cycle();
        pc    = 32'h0000_4000;
        instr = enc_jal(5'd1, 21'h400);
        expect_pred(32'h4400, 1'b1);
        next_cycle();
        pc    = 32'h0000_4400;
        instr = enc_jal(5'd1, 21'h200);
        expect_pred(32'h4600, 1'b1);
        next_cycle();
        pc       = 32'h0000_4600;
        instr    = enc_jalr(5'd1, 5'd5, 12'h010);
        rs1_data = 32'h0000_5000;
        expect_pred(32'h5010, 1'b1);
        next_cycle();
        pc    = 32'h0000_5010;
        instr = enc_jalr(5'd0, 5'd1, 12'h000);
        expect_pred(32'h4604, 1'b1);
        next_cycle();
        pc = 32'h0000_4604;
        expect_pred(32'h4404, 1'b1);
        next_cycle();
        pc = 32'h0000_4404;
        expect_pred(32'h4004, 1'b1);
        finish_test("calls and returns");

        next_cycle();
        pc          = 32'h0000_6000;
        instr       = enc_jal(5'd1, 21'h080);
        old_pc      = 32'h0000_7000;
        old_actual  = 1'b1;
        expect_pred(32'h7000, 1'b1);
        check("predict_fail", 32'(predict_fail), 32'd1);
        next_cycle();
        instr       = enc_branch(13'h020);
        old_pc      = 32'h0000_7100;
        old_predict = 1'b1;
        old_actual  = 1'b0;
        expect_pred(32'h7100, 1'b0);
        check("predict_fail", 32'(predict_fail), 32'd1);
        next_cycle();
        quiet_execute();
        instr = {25'h0, OP_IMM};
        expect_pred(32'h6004, 1'b0);
        check("predict_fail", 32'(predict_fail), 32'd0);
        finish_test("mispredict redirect");

        next_cycle();
        pc    = 32'h0000_8000;
        instr = enc_jal(5'd1, 21'h100);
        expect_pred(32'h8100, 1'b1);
        next_cycle();
        pc    = 32'h0000_8100;
        instr = enc_jal(5'd1, 21'h040); // call that the trap must not push
        excp  = 1'b1;
        #20;
        check("target_pc", target_pc, `EXCP_ADDR);
        next_cycle();
        excp  = 1'b0;
        pc    = 32'h0000_8200;
        instr = enc_jalr(5'd0, 5'd1, 12'h000);
        expect_pred(32'h8004, 1'b1);
        check("sepc", sepc, 32'h0000_8104);
        finish_test("exception");

        for (int i = 0; i < (1 << `RAS_BITS); i++) begin
            next_cycle();
            pc    = 32'h0000_9000 + 32'(8 * i); // every stack entry gets written
            instr = enc_jal(5'd1, 21'h100);
        end
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            next_cycle();
            sel = 2'(rand_bits(2));
            pc  = 32'h0000_1000 + (rand_bits(4) << 2);
            case (sel)
                2'd0: instr = {25'(rand_bits(25)), OP_IMM};
                2'd1: instr = enc_branch(13'(rand_bits(13)));
                2'd2: instr = enc_jal(rand_bits(1) ? 5'd1 : 5'd5, 21'(rand_bits(21)));
                default: instr = enc_jalr(rand_bits(1) ? 5'd1 : 5'd0,
                                          rand_bits(1) ? 5'd1 : 5'd6, 12'(rand_bits(12)));
            endcase
            rs1_data      = rand_bits(32);
            old_branch    = 1'(rand_bits(1));
            old_branch_pc = 32'h0000_1000 + (rand_bits(4) << 2);
            old_actual    = 1'(rand_bits(1));
            old_predict   = (rand_bits(2) == 0) ? !old_actual : old_actual;
            excp          = (old_predict == old_actual) && (rand_bits(4) == 0);
            stall         = (rand_bits(2) == 0);
            old_pc        = rand_bits(32) & 32'hffff_fffc;
        end
        finish_test("random mix");

        $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/bp_pkg.sv
hdl/branch_decode.sv
hdl/pattern_table.sv
hdl/return_stack.sv
hdl/branch_predictor.sv
hdl/frontend_top.sv
bench/tb_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module tb_frontend \
    -o sim_frontend

./obj_dir/sim_frontend > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
